// ==== csr_index_generator.f ====
+incdir+design
+incdir+dv
design/csr_index_pkg.sv
design/index_push_if.sv
design/csr_index_sequencer.sv
design/index_request_fifo.sv
design/request_out_stage.sv
design/csr_index_generator.sv
dv/csr_index_generator_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the CSR index generator testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_csr_index_generator
LOG_FILE=sim.log

verilator --binary --timing --timescale 1ns/1ns \
    --top-module csr_index_generator_tb \
    -f csr_index_generator.f \
    --Mdir "${BUILD_DIR}" -o "${SIM_BIN}"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./${BUILD_DIR}/${SIM_BIN}" > "${LOG_FILE}" 2>&1
sim_status=$?
cat "${LOG_FILE}"
if [ ${sim_status} -ne 0 ]; then
    echo "Simulator exited with status ${sim_status}"
    exit 1
fi

if grep -q "Simulation FAILED" "${LOG_FILE}"; then
    exit 1
fi
exit 0

// ==== dv/csr_index_tests.svh ====
// Directed tests for the CSR index generator; included inside the testbench top module
`ifndef CSR_INDEX_TESTS_SVH
`define CSR_INDEX_TESTS_SVH

// ------------------------------------------------
// Plain ranges
// ------------------------------------------------
task automatic test_basic_left_shift();
    string name = "test_basic_left_shift";
    clear_scoreboard(name);
    build_expected(4, 12, 1, 1'b1, 5'd2);
    apply_config(4, 12, 1, 1'b1, 5'd2);
    wait_for_done(name);
    wait_for_drain();
    compare_requests(name);
endtask

// Last index 28 sits just below the end
task automatic test_stride_right_shift();
    string name = "test_stride_right_shift";
    clear_scoreboard(name);
    build_expected(10, 30, 3, 1'b0, 5'd1);
    apply_config(10, 30, 3, 1'b0, 5'd1);
    wait_for_done(name);
    wait_for_drain();
    compare_requests(name);
endtask

task automatic test_empty_range();
    string name = "test_empty_range";
    clear_scoreboard(name);
    build_expected(50, 50, 1, 1'b1, 5'd0);
    apply_config(50, 50, 1, 1'b1, 5'd0);
    wait_for_done(name);
    step_cycle();
    check_flag(name, "cfg_ready after done", 1'b1, cfg_ready);
    wait_for_drain();
    compare_requests(name);
endtask

// ------------------------------------------------
// Flow control
// ------------------------------------------------
task automatic test_backpressure();
    string name = "test_backpressure";
    clear_scoreboard(name);
    build_expected(1000, 1160, 4, 1'b1, 5'd3);
    random_ready = 1'b1;
    apply_config(1000, 1160, 4, 1'b1, 5'd3);
    wait_for_done(name);
    wait_for_drain();
    random_ready = 1'b0;
    req_ready <= 1'b1;
    compare_requests(name);
endtask

// Pause lands after a few requests have left
// Without the stall the whole range would finish inside the pause window
task automatic test_pause();
    string name = "test_pause";
    clear_scoreboard(name);
    build_expected(200, 240, 2, 1'b0, 5'd3);
    apply_config(200, 240, 2, 1'b0, 5'd3);
    while (got_index.size() < 5) begin
        step_cycle();
    end
    pause <= 1'b1;
    repeat (PAUSE_CYCLES) begin
        step_cycle();
        check_flag(name, "done while paused", 1'b0, done);
    end
    pause <= 1'b0;
    wait_for_done(name);
    wait_for_drain();
    compare_requests(name);
endtask

`endif

// ==== dv/csr_index_generator_tb.sv ====
// Testbench top for the CSR index generator; compile with the file list and run with Verilator
`timescale 1ns/1ns
`default_nettype none

`include "csr_index_defs.svh"

module csr_index_generator_tb;

    // Expected requests over all tests, used to size the watchdog
    localparam int TOTAL_REQS      = 75;
    localparam int CYCLES_PER_REQ  = 10;
    localparam int TEST_OVERHEAD   = 60;
    localparam int PAUSE_CYCLES    = 30;
    localparam int WATCHDOG_CYCLES = TOTAL_REQS * CYCLES_PER_REQ + 5 * TEST_OVERHEAD
                                     + PAUSE_CYCLES;

    logic                ap_clk;
    logic                areset_engine;
    logic                cfg_valid;
    logic                cfg_ready;
    logic [`INDEX_W-1:0] cfg_index_start;
    logic [`INDEX_W-1:0] cfg_index_end;
    logic [`INDEX_W-1:0] cfg_stride;
    logic                cfg_shift_left;
    logic [`SHIFT_W-1:0] cfg_shift_amount;
    logic                pause;
    logic                done;
    logic                req_valid;
    logic                req_ready;
    logic [`INDEX_W-1:0] req_index;
    logic [`INDEX_W-1:0] req_base;
    logic [`INDEX_W-1:0] req_offset;

    // ------------------------------------------------
    // Scoreboard state
    // ------------------------------------------------
    logic [`INDEX_W-1:0] exp_index [$];
    logic [`INDEX_W-1:0] exp_base [$];
    logic [`INDEX_W-1:0] exp_offset [$];
    logic [`INDEX_W-1:0] got_index [$];
    logic [`INDEX_W-1:0] got_base [$];
    logic [`INDEX_W-1:0] got_offset [$];
    int                  done_count;
    int                  error_count;
    int                  check_count;
    integer              seed;
    logic                random_ready;

    csr_index_generator i_csr_index_generator (
        .ap_clk           (ap_clk),
        .areset_engine    (areset_engine),
        .cfg_valid        (cfg_valid),
        .cfg_ready        (cfg_ready),
        .cfg_index_start  (cfg_index_start),
        .cfg_index_end    (cfg_index_end),
        .cfg_stride       (cfg_stride),
        .cfg_shift_left   (cfg_shift_left),
        .cfg_shift_amount (cfg_shift_amount),
        .pause            (pause),
        .done             (done),
        .req_valid        (req_valid),
        .req_ready        (req_ready),
        .req_index        (req_index),
        .req_base         (req_base),
        .req_offset       (req_offset)
    );

    initial begin
        ap_clk = 1'b0;
        forever #5 ap_clk = ~ap_clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge ap_clk);
        $display("Watchdog expired, the tests did not finish in time");
        $display("Simulation FAILED");
        $finish;
    end

    // ------------------------------------------------
    // Cycle step, request collector and checks
    // ------------------------------------------------
    // Samples pre-edge values, then drives the next ready level
    task automatic step_cycle();
        logic [31:0] rand_word;
        @(posedge ap_clk);
        if (req_valid && req_ready) begin
            got_index.push_back(req_index);
            got_base.push_back(req_base);
            got_offset.push_back(req_offset);
        end
        if (done) begin
            done_count++;
        end
        if (random_ready) begin
            rand_word = $random(seed);
            req_ready <= rand_word[0];
        end
    endtask

    task automatic check_index(input string test_name, input string what,
                               input logic [`INDEX_W-1:0] expected,
                               input logic [`INDEX_W-1:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR %s: %s expected %0d, actual %0d", test_name, what, expected, actual);
        end
    endtask

    task automatic check_flag(input string test_name, input string what,
                              input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR %s: %s expected %0b, actual %0b", test_name, what, expected, actual);
        end
    endtask

    // ------------------------------------------------
    // Reference model
    // ------------------------------------------------
    task automatic build_expected(input logic [`INDEX_W-1:0] start,
                                  input logic [`INDEX_W-1:0] end_index,
                                  input logic [`INDEX_W-1:0] stride,
                                  input logic shift_left,
                                  input logic [`SHIFT_W-1:0] amount);
        logic [`INDEX_W-1:0] idx;
        logic [`INDEX_W-1:0] scale;
        idx   = start;
        scale = `INDEX_W'(1) << amount;
        while (idx < end_index) begin
            exp_index.push_back(idx);
            exp_base.push_back(start);
            // Left multiplies by the power of two, right divides
            exp_offset.push_back(shift_left ? idx * scale : idx / scale);
            idx = idx + stride;
        end
    endtask

    task automatic clear_scoreboard(input string test_name);
        exp_index.delete();
        exp_base.delete();
        exp_offset.delete();
        got_index.delete();
        got_base.delete();
        got_offset.delete();
        done_count = 0;
        $display("Running %s", test_name);
    endtask

    task automatic apply_config(input logic [`INDEX_W-1:0] start,
                                input logic [`INDEX_W-1:0] end_index,
                                input logic [`INDEX_W-1:0] stride,
                                input logic shift_left,
                                input logic [`SHIFT_W-1:0] amount);
        logic accepted;
        accepted = 1'b0;
        cfg_valid        <= 1'b1;
        cfg_index_start  <= start;
        cfg_index_end    <= end_index;
        cfg_stride       <= stride;
        cfg_shift_left   <= shift_left;
        cfg_shift_amount <= amount;
        while (!accepted) begin
            step_cycle();
            accepted = cfg_ready;
        end
        cfg_valid <= 1'b0;
    endtask

    // cfg_ready must stay low from acceptance through the done cycle
    task automatic wait_for_done(input string test_name);
        while (done_count == 0) begin
            step_cycle();
            check_flag(test_name, "cfg_ready while busy", 1'b0, cfg_ready);
        end
    endtask

    task automatic wait_for_drain();
        while (got_index.size() < exp_index.size()) begin
            step_cycle();
        end
        // A few more cycles to catch extra requests
        repeat (6) step_cycle();
    endtask

    task automatic compare_requests(input string test_name);
        check_index(test_name, "request count", `INDEX_W'(exp_index.size()),
                    `INDEX_W'(got_index.size()));
        for (int i = 0; i < exp_index.size() && i < got_index.size(); i++) begin
            check_index(test_name, "req_index", exp_index[i], got_index[i]);
            check_index(test_name, "req_base", exp_base[i], got_base[i]);
            check_index(test_name, "req_offset", exp_offset[i], got_offset[i]);
        end
        check_index(test_name, "done pulses", `INDEX_W'(1), `INDEX_W'(done_count));
    endtask

    `include "csr_index_tests.svh"

    // ------------------------------------------------
    // Main sequence
    // ------------------------------------------------
    initial begin
        seed         = 34;
        random_ready = 1'b0;
        error_count  = 0;
        check_count  = 0;
        done_count   = 0;
        cfg_valid        <= 1'b0;
        cfg_index_start  <= '0;
        cfg_index_end    <= '0;
        cfg_stride       <= '0;
        cfg_shift_left   <= 1'b0;
        cfg_shift_amount <= '0;
        pause            <= 1'b0;
        req_ready        <= 1'b1;
        areset_engine    <= 1'b1;
        repeat (3) @(posedge ap_clk);
        areset_engine <= 1'b0;

        test_basic_left_shift();
        test_stride_right_shift();
        test_empty_range();
        test_backpressure();
        test_pause();

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/csr_index_generator.sv ====
// Top level of the CSR index generator; plain configuration and request ports for the read engine
`timescale 1ns/1ns
`default_nettype none

`include "csr_index_defs.svh"

module csr_index_generator
    import csr_index_pkg::*;
(
    input  logic                ap_clk,
    input  logic                areset_engine,
    // Configuration
    input  logic                cfg_valid,
    output logic                cfg_ready,
    input  logic [`INDEX_W-1:0] cfg_index_start,
    input  logic [`INDEX_W-1:0] cfg_index_end,
    input  logic [`INDEX_W-1:0] cfg_stride,
    input  logic                cfg_shift_left,
    input  logic [`SHIFT_W-1:0] cfg_shift_amount,
    // Control
    input  logic                pause,
    output logic                done,
    // Memory requests
    output logic                req_valid,
    input  logic                req_ready,
    output logic [`INDEX_W-1:0] req_index,
    output logic [`INDEX_W-1:0] req_base,
    output logic [`INDEX_W-1:0] req_offset
);

    // ------------------------------------------------
    // Configuration packing
    // ------------------------------------------------
    csr_index_cfg_t cfg;
    index_entry_t   fifo_entry;
    logic           fifo_valid;
    logic           fifo_ready;

    always_comb begin
        cfg.index_start  = cfg_index_start;
        cfg.index_end    = cfg_index_end;
        cfg.stride       = cfg_stride;
        cfg.shift_dir    = cfg_shift_left ? SHIFT_LEFT : SHIFT_RIGHT;
        cfg.shift_amount = cfg_shift_amount;
    end

    // ------------------------------------------------
    // Sequencer, FIFO, output stage
    // ------------------------------------------------
    index_push_if i_index_push ();

    csr_index_sequencer i_csr_index_sequencer (
        .ap_clk        (ap_clk),
        .areset_engine (areset_engine),
        .cfg_valid     (cfg_valid),
        .cfg           (cfg),
        .cfg_ready     (cfg_ready),
        .pause         (pause),
        .done          (done),
        .push          (i_index_push.push)
    );

    index_request_fifo i_index_request_fifo (
        .ap_clk        (ap_clk),
        .areset_engine (areset_engine),
        .push          (i_index_push.sink),
        .fifo_valid    (fifo_valid),
        .fifo_entry    (fifo_entry),
        .fifo_ready    (fifo_ready)
    );

    request_out_stage i_request_out_stage (
        .ap_clk        (ap_clk),
        .areset_engine (areset_engine),
        .fifo_valid    (fifo_valid),
        .fifo_entry    (fifo_entry),
        .fifo_ready    (fifo_ready),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req_index     (req_index),
        .req_base      (req_base),
        .req_offset    (req_offset)
    );

endmodule : csr_index_generator

`default_nettype wire

// ==== design/request_out_stage.sv ====
// Output register that turns FIFO entries into memory requests with the shifted address offset
`timescale 1ns/1ns
`default_nettype none

`include "csr_index_defs.svh"

module request_out_stage
    import csr_index_pkg::*;
(
    input  logic                ap_clk,
    input  logic                areset_engine,
    input  logic                fifo_valid,
    input  index_entry_t        fifo_entry,
    output logic                fifo_ready,
    output logic                req_valid,
    input  logic                req_ready,
    output logic [`INDEX_W-1:0] req_index,
    output logic [`INDEX_W-1:0] req_base,
    output logic [`INDEX_W-1:0] req_offset
);

    logic [`INDEX_W-1:0] offset_next;
    logic                pop;

    // Pop when the register is empty or is draining this cycle
    assign fifo_ready = !req_valid || req_ready;
    assign pop        = fifo_valid && fifo_ready;

    always_comb begin
        if (fifo_entry.shift_dir == SHIFT_LEFT) begin
            offset_next = fifo_entry.index << fifo_entry.shift_amount;
        end else begin
            offset_next = fifo_entry.index >> fifo_entry.shift_amount;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            req_valid <= 1'b0;
        end else if (pop) begin
            req_valid <= 1'b1;
        end else if (req_ready) begin
            req_valid <= 1'b0;
        end
    end

    // Fields hold while the consumer stalls
    always_ff @(posedge ap_clk) begin
        if (pop) begin
            req_index  <= fifo_entry.index;
            req_base   <= fifo_entry.base;
            req_offset <= offset_next;
        end
    end

endmodule : request_out_stage

`default_nettype wire

// ==== design/index_request_fifo.sv ====
// First-word-fall-through request FIFO with programmable full, between sequencer and output stage
`timescale 1ns/1ns
`default_nettype none

`include "csr_index_defs.svh"

module index_request_fifo
    import csr_index_pkg::*;
(
    input  logic       ap_clk,
    input  logic       areset_engine,
    index_push_if.sink push,
    output logic       fifo_valid,
    output index_entry_t fifo_entry,
    input  logic       fifo_ready
);

    localparam int PTR_W = $clog2(`REQ_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`REQ_FIFO_DEPTH + 1);

    // ------------------------------------------------
    // Storage and pointers
    // ------------------------------------------------
    index_entry_t     mem [`REQ_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fill_count;
    logic             wr_en;
    logic             rd_en;

    assign wr_en = push.valid && push.ready;
    assign rd_en = fifo_valid && fifo_ready;

    always_ff @(posedge ap_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push.entry;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fill_count <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(`REQ_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(`REQ_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves the level unchanged
            if (wr_en && !rd_en) begin
                fill_count <= fill_count + 1'b1;
            end else if (rd_en && !wr_en) begin
                fill_count <= fill_count - 1'b1;
            end
        end
    end

    // ------------------------------------------------
    // Status and head
    // ------------------------------------------------
    assign push.ready     = (fill_count != CNT_W'(`REQ_FIFO_DEPTH));
    assign push.prog_full = (fill_count >= CNT_W'(`REQ_FIFO_PROG_THRESH));

    // Head is visible the cycle after it is written
    assign fifo_valid = (fill_count != '0);
    assign fifo_entry = mem[rd_ptr];

endmodule : index_request_fifo

`default_nettype wire

// ==== design/csr_index_sequencer.sv ====
// FSM and stride counter that take one configuration and push its index entries to the FIFO
`timescale 1ns/1ns
`default_nettype none

`include "csr_index_defs.svh"

module csr_index_sequencer
    import csr_index_pkg::*;
(
    input  logic           ap_clk,
    input  logic           areset_engine,
    input  logic           cfg_valid,
    input  csr_index_cfg_t cfg,
    output logic           cfg_ready,
    input  logic           pause,
    output logic           done,
    index_push_if.push     push
);

    // ------------------------------------------------
    // Local signals
    // ------------------------------------------------
    seq_state_e          state;
    seq_state_e          next_state;
    csr_index_cfg_t      cfg_q;
    logic [`INDEX_W-1:0] index_count;
    logic                cfg_accept;
    logic                below_end;
    logic                stalled;
    logic                push_fire;

    assign cfg_accept = cfg_valid && cfg_ready;
    assign below_end  = (index_count < cfg_q.index_end);
    assign stalled    = push.prog_full || pause;
    assign push_fire  = push.valid && push.ready;

    // ------------------------------------------------
    // Configuration latch
    // ------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (cfg_accept) begin
            cfg_q <= cfg;
        end
    end

    // ------------------------------------------------
    // FSM
    // ------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            state     <= SEQ_IDLE;
            cfg_ready <= 1'b0;
        end else begin
            state     <= next_state;
            // Ready follows the state, but stays low through reset
            cfg_ready <= (next_state == SEQ_IDLE);
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            SEQ_IDLE: begin
                if (cfg_accept) begin
                    next_state = SEQ_SETUP;
                end
            end
            SEQ_SETUP: begin
                next_state = SEQ_BUSY;
            end
            SEQ_BUSY: begin
                if (!below_end) begin
                    next_state = SEQ_DONE;
                end else if (stalled) begin
                    next_state = SEQ_PAUSE;
                end
            end
            SEQ_PAUSE: begin
                if (!stalled) begin
                    next_state = SEQ_BUSY;
                end
            end
            SEQ_DONE: begin
                next_state = SEQ_IDLE;
            end
            default: begin
                next_state = SEQ_IDLE;
            end
        endcase
    end

    // One-cycle pulse as the range runs out
    assign done = (state == SEQ_DONE);

    // ------------------------------------------------
    // Stride counter
    // ------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (state == SEQ_SETUP) begin
            index_count <= cfg_q.index_start;
        end else if (push_fire) begin
            index_count <= index_count + cfg_q.stride;
        end
    end

    // ------------------------------------------------
    // Entry push
    // ------------------------------------------------
    // Stall inputs gate the push in the same cycle, so nothing leaks past prog_full
    assign push.valid = (state == SEQ_BUSY) && below_end && !stalled;

    always_comb begin
        push.entry.index        = index_count;
        push.entry.base         = cfg_q.index_start;
        push.entry.shift_dir    = cfg_q.shift_dir;
        push.entry.shift_amount = cfg_q.shift_amount;
    end

endmodule : csr_index_sequencer

`default_nettype wire

// ==== design/index_push_if.sv ====
// Push link from the index sequencer into the request FIFO; instantiated once in the top level
`timescale 1ns/1ns
`default_nettype none

interface index_push_if
    import csr_index_pkg::*;
();

    // Producer side
    logic         valid;
    index_entry_t entry;

    // Not full
    logic ready;
    // Fill level at or above threshold
    logic prog_full;

    modport push (
        output valid,
        output entry,
        input  ready,
        input  prog_full
    );

    modport sink (
        input  valid,
        input  entry,
        output ready,
        output prog_full
    );

endinterface : index_push_if

`default_nettype wire

// ==== design/csr_index_pkg.sv ====
// Types for the CSR index generator; imported by the modules and the interface that use them
`default_nettype none

`include "csr_index_defs.svh"

package csr_index_pkg;

    // ------------------------------------------------
    // Sequencer FSM
    // ------------------------------------------------
    typedef enum logic [2:0] {
        SEQ_IDLE  = 3'd0,
        SEQ_SETUP = 3'd1,
        SEQ_BUSY  = 3'd2,
        SEQ_PAUSE = 3'd3,
        SEQ_DONE  = 3'd4
    } seq_state_e;

    // Shift opcode for the address offset
    typedef enum logic {
        SHIFT_RIGHT = 1'b0,
        SHIFT_LEFT  = 1'b1
    } shift_dir_e;

    // ------------------------------------------------
    // Configuration and FIFO payload
    // ------------------------------------------------
    typedef struct packed {
        logic [`INDEX_W-1:0] index_start;
        logic [`INDEX_W-1:0] index_end;
        logic [`INDEX_W-1:0] stride;
        shift_dir_e          shift_dir;
        logic [`SHIFT_W-1:0] shift_amount;
    } csr_index_cfg_t;

    // Shift settings ride along since the offset is built after the FIFO
    typedef struct packed {
        logic [`INDEX_W-1:0] index;
        logic [`INDEX_W-1:0] base;
        shift_dir_e          shift_dir;
        logic [`SHIFT_W-1:0] shift_amount;
    } index_entry_t;

endpackage : csr_index_pkg

`default_nettype wire

// ==== design/csr_index_defs.svh ====
// Width and depth macros shared by the CSR index generator RTL; include wherever a size is needed
`ifndef CSR_INDEX_DEFS_SVH
`define CSR_INDEX_DEFS_SVH

// ------------------------------------------------
// Datapath widths
// ------------------------------------------------

// Index, stride, base and offset
`define INDEX_W 32

// Shift amount, enough for 0..31
`define SHIFT_W 5

// ------------------------------------------------
// Request FIFO sizing
// ------------------------------------------------

`define REQ_FIFO_DEPTH 16

// Leaves headroom for entries still in flight from the sequencer
`define REQ_FIFO_PROG_THRESH 8

`endif
